//--- files.f
logic/rh11Pkg.sv
logic/rhBusAddr.sv
logic/rhWordCount.sv
logic/rhXferCtrl.sv
logic/rhDma.sv
sim/rhDmaTb.sv

//--- Bender.yml
package:
  name: rh11_dma

sources:
  - files:
      - logic/rh11Pkg.sv
      - logic/rhBusAddr.sv
      - logic/rhWordCount.sv
      - logic/rhXferCtrl.sv
      - logic/rhDma.sv
  - target: simulation
    files:
      - sim/rhDmaTb.sv

//--- sim/rhDmaTb.sv
// Random-stimulus testbench for the RH11 DMA register block, checks every cycle against a model
`timescale 1ns/100ps

module rhDmaTb;

   import rh11Pkg::*;

   // Cycles allowed for one block transfer to finish
   localparam int XferTimeout = 400;

   logic                  clk;
   logic                  rst;
   logic                  clr;
   logic                  devLoByte;
   logic                  devHiByte;
   logic [DevWidth-1:0]   devBus;
   logic                  cs1Write;
   logic                  baWrite;
   logic                  wcWrite;
   logic                  xferWord;
   logic [BaWidth-1:0]    rhBa;
   logic [WcWidth-1:0]    rhWc;
   logic [15:0]           rhCs1;
   logic                  rhRdy;
   logic                  intr;

   // Model state
   logic [BaWidth-1:0]    mBa;
   logic [WcWidth-1:0]    mWc;
   logic                  mIe;
   logic                  mRdy;
   logic                  mIntr;

   logic [31:0]           lfsr = 32'h946d7ccd;

   rhDma rhDma_inst
   (
      .clk       (clk),
      .rst       (rst),
      .clr       (clr),
      .devLoByte (devLoByte),
      .devHiByte (devHiByte),
      .devDataI  (devBus),
      .cs1Write  (cs1Write),
      .baWrite   (baWrite),
      .wcWrite   (wcWrite),
      .xferWord  (xferWord),
      .rhBa      (rhBa),
      .rhWc      (rhWc),
      .rhCs1     (rhCs1),
      .rhRdy     (rhRdy),
      .intr      (intr)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Random bits, taps 32 22 2 1
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] randBits(input int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         val  = {val[30:0], fb};
      end
      return val;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Failure and compare
   //////////////////////////////////////////////////////////////////////

   task automatic abortRun();
      $display("Test FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic checkBa(input string name, input logic [BaWidth-1:0] expV,
                          input logic [BaWidth-1:0] actV);
      if (actV !== expV)
      begin
         $display("Error: %s expected %h actual %h", name, expV, actV);
         abortRun();
      end
   endtask

   task automatic checkWc(input string name, input logic [WcWidth-1:0] expV,
                          input logic [WcWidth-1:0] actV);
      if (actV !== expV)
      begin
         $display("Error: %s expected %h actual %h", name, expV, actV);
         abortRun();
      end
   endtask

   task automatic checkCs1(input string name, input logic [15:0] expV, input logic [15:0] actV);
      if (actV !== expV)
      begin
         $display("Error: %s expected %h actual %h", name, expV, actV);
         abortRun();
      end
   endtask

   task automatic checkFlag(input string name, input logic expV, input logic actV);
      if (actV !== expV)
      begin
         $display("Error: %s expected %h actual %h", name, expV, actV);
         abortRun();
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Reference model, one clock edge
   //////////////////////////////////////////////////////////////////////

   task automatic updateModel();
      logic               step;
      logic               wrap;
      logic [15:0]        w;
      logic [BaWidth-1:0] nBa;
      logic [WcWidth-1:0] nWc;
      logic               nIe;
      logic               nRdy;
      w    = devBus[15:0];
      step = xferWord && !mRdy;
      // Count about to hit zero, a WC write cancels the step
      wrap = step && !wcWrite && (mWc == 16'hffff);
      nBa  = mBa;
      nWc  = mWc;
      nIe  = mIe;
      nRdy = mRdy;
      // BAE field sits in CS1 bits 9:8
      if (cs1Write && devHiByte && mRdy)
         nBa[17:16] = w[9:8];
      if (baWrite)
      begin
         if (devHiByte)
            nBa[15:8] = w[15:8];
         if (devLoByte)
            nBa[7:0] = w[7:0];
      end
      else if (step)
         nBa = mBa + 18'd2;
      if (wcWrite)
      begin
         if (devHiByte)
            nWc[15:8] = w[15:8];
         if (devLoByte)
            nWc[7:0] = w[7:0];
      end
      else if (step)
         nWc = mWc + 16'd1;
      // IE in bit 6, GO in bit 0
      if (cs1Write && devLoByte && mRdy)
      begin
         nIe = w[6];
         if (w[0])
            nRdy = 1'b0;
      end
      else if (wrap)
         nRdy = 1'b1;
      mIntr = clr ? 1'b0 : (wrap && mIe);
      mBa   = clr ? '0 : nBa;
      mWc   = clr ? '0 : nWc;
      mIe   = clr ? 1'b0 : nIe;
      mRdy  = clr ? 1'b1 : nRdy;
   endtask

   task automatic checkAll();
      logic [15:0] expCs1;
      expCs1 = {6'b0, mBa[17:16], mRdy, mIe, 6'b0};
      checkBa("rhBa", mBa, rhBa);
      checkWc("rhWc", mWc, rhWc);
      checkCs1("rhCs1", expCs1, rhCs1);
      checkFlag("rhRdy", mRdy, rhRdy);
      checkFlag("intr", mIntr, intr);
   endtask

   // One cycle: model takes the edge, new inputs go out, outputs checked mid-cycle
   task automatic tick(input logic c1W, input logic bW, input logic wW, input logic lo,
                       input logic hi, input logic [15:0] word, input logic xw,
                       input logic clrIn);
      logic [31:0] upper;
      @(posedge clk);
      updateModel();
      upper = randBits(20);
      cs1Write  <= c1W;
      baWrite   <= bW;
      wcWrite   <= wW;
      devLoByte <= lo;
      devHiByte <= hi;
      devBus    <= {upper[19:0], word};
      xferWord  <= xw;
      clr       <= clrIn;
      @(negedge clk);
      checkAll();
   endtask

   //////////////////////////////////////////////////////////////////////
   // One block transfer
   //////////////////////////////////////////////////////////////////////

   task automatic runTransfer(input logic ieVal, input logic withClr);
      logic [31:0] r;
      logic [3:0]  len;
      logic [15:0] cs1Word;
      logic        intrSeen;
      int          cycles;
      len = 4'(randBits(3)) + 4'd1;
      // Long enough that the clear lands before the end
      if (withClr)
         len = 4'd8;
      r = randBits(16);
      tick(1'b0, 1'b1, 1'b0, 1'b1, 1'b1, r[15:0], 1'b0, 1'b0);
      tick(1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 16'h0 - 16'(len), 1'b0, 1'b0);
      r = randBits(2);
      cs1Word = {6'b0, r[1:0], 1'b0, ieVal, 5'b0, 1'b1};
      tick(1'b1, 1'b0, 1'b0, 1'b1, 1'b1, cs1Word, 1'b0, 1'b0);
      // GO lands on this edge, controller goes busy
      tick(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 16'h0, 1'b0, 1'b0);
      checkFlag("rhRdy after GO", 1'b0, rhRdy);
      cycles   = 0;
      intrSeen = 1'b0;
      while (rhRdy == 1'b0 && cycles < XferTimeout)
      begin
         r = randBits(8);
         if (withClr && cycles == 2)
            tick(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 16'h0, r[3], 1'b1);
         else if (!withClr && r[2:0] == 3'd0)
            // Busy writes beside a step, short even count keeps the block bounded
            tick(1'b1, 1'b1, 1'b1, 1'b1, 1'b1, {13'h1fff, r[6:5], 1'b0}, 1'b1, 1'b0);
         else
            tick(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 16'h0, r[3], 1'b0);
         intrSeen = intrSeen | intr;
         cycles++;
      end
      if (rhRdy != 1'b1)
      begin
         $display("Timeout: controller not ready after %0d cycles of transfer", cycles);
         abortRun();
      end
      repeat (2)
      begin
         tick(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 16'h0, 1'b0, 1'b0);
         intrSeen = intrSeen | intr;
      end
      checkFlag("intr pulse", ieVal && !withClr, intrSeen);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      logic [31:0] r;
      logic [31:0] w;
      rst       <= 1'b1;
      clr       <= 1'b0;
      devLoByte <= 1'b0;
      devHiByte <= 1'b0;
      devBus    <= '0;
      cs1Write  <= 1'b0;
      baWrite   <= 1'b0;
      wcWrite   <= 1'b0;
      xferWord  <= 1'b0;
      mBa   = '0;
      mWc   = '0;
      mIe   = 1'b0;
      mRdy  = 1'b1;
      mIntr = 1'b0;
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      checkAll();

      // Byte-lane writes while idle, stray drive words ignored
      repeat (40)
      begin
         r = randBits(5);
         w = randBits(16);
         tick(1'b0, r[0], r[1], r[2], r[3], w[15:0], r[4], 1'b0);
      end

      // CS1 writes without GO, BAE and IE only
      repeat (12)
      begin
         r = randBits(2);
         w = randBits(16);
         tick(1'b1, 1'b0, 1'b0, r[0], r[1], {w[15:1], 1'b0}, 1'b0, 1'b0);
      end

      // Transfers with both IE values, one cleared midway
      for (int t = 0; t < 8; t++)
      begin
         runTransfer(t[0], t == 5);
         repeat (3)
            tick(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 16'h0, 1'b1, 1'b0);
      end

      $display("Test OK");
      $finish;
   end

endmodule

//--- logic/rhDma.sv
// RH11 DMA register block top: address and count registers beside the transfer controller
`timescale 1ns/100ps

module rhDma
(
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           clr,
   input  logic                           devLoByte,
   input  logic                           devHiByte,
   input  logic [0:rh11Pkg::DevWidth-1]   devDataI,
   input  logic                           cs1Write,
   input  logic                           baWrite,
   input  logic                           wcWrite,
   input  logic                           xferWord,
   output logic [rh11Pkg::BaWidth-1:0]    rhBa,
   output logic [rh11Pkg::WcWidth-1:0]    rhWc,
   output logic [15:0]                    rhCs1,
   output logic                           rhRdy,
   output logic                           intr
);

   import rh11Pkg::*;

   // Bus word renumbered, PDP-10 bit 35 becomes bit 0
   devWord_t devWord;

   // One pulse per accepted drive word
   logic stepXfer;

   // Last word of the block
   logic wcWrap;

   assign devWord = devDataI;

   //////////////////////////////////////////////////////////////////////
   // Register instances
   //////////////////////////////////////////////////////////////////////

   rhBusAddr rhBusAddr_inst
   (
      .clk       (clk),
      .rst       (rst),
      .clr       (clr),
      .devLoByte (devLoByte),
      .devHiByte (devHiByte),
      .devData   (devWord),
      .baWrite   (baWrite),
      .cs1Write  (cs1Write),
      .rhRdy     (rhRdy),
      .stepXfer  (stepXfer),
      .rhBa      (rhBa)
   );

   rhWordCount rhWordCount_inst
   (
      .clk       (clk),
      .rst       (rst),
      .clr       (clr),
      .devLoByte (devLoByte),
      .devHiByte (devHiByte),
      .devData   (devWord),
      .wcWrite   (wcWrite),
      .stepXfer  (stepXfer),
      .rhWc      (rhWc),
      .wcWrap    (wcWrap)
   );

   // BAE readback comes from the top of the address
   rhXferCtrl rhXferCtrl_inst
   (
      .clk       (clk),
      .rst       (rst),
      .clr       (clr),
      .devLoByte (devLoByte),
      .devHiByte (devHiByte),
      .devData   (devWord),
      .cs1Write  (cs1Write),
      .xferWord  (xferWord),
      .wcWrap    (wcWrap),
      .baExt     (rhBa[17:16]),
      .stepXfer  (stepXfer),
      .rhRdy     (rhRdy),
      .intr      (intr),
      .rhCs1     (rhCs1)
   );

endmodule

//--- logic/rhXferCtrl.sv
// RH11 transfer control: GO/IE handling, step gating, completion interrupt and RHCS1 status word
`timescale 1ns/100ps

module rhXferCtrl
(
   input  logic               clk,
   input  logic               rst,
   input  logic               clr,
   input  logic               devLoByte,
   input  logic               devHiByte,
   input  rh11Pkg::devWord_t  devData,
   input  logic               cs1Write,
   input  logic               xferWord,
   input  logic               wcWrap,
   input  logic [1:0]         baExt,
   output logic               stepXfer,
   output logic               rhRdy,
   output logic               intr,
   output logic [15:0]        rhCs1
);

   import rh11Pkg::*;

   //////////////////////////////////////////////////////////////////////
   // CS1 low byte decode
   //////////////////////////////////////////////////////////////////////

   // Latched interrupt enable
   logic ieReg;

   // Low byte write accepted, idle only
   logic cs1LoLoad;

   // GO seen in an accepted write
   logic goStart;

   assign cs1LoLoad = cs1Write && devLoByte && rhRdy;
   assign goStart   = cs1LoLoad && devData.cs1.go;

   // Drive words count only while busy, no buffering
   assign stepXfer = xferWord && !rhRdy;

   //////////////////////////////////////////////////////////////////////
   // Ready, IE and interrupt state
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rhRdy <= 1'b1;
         ieReg <= 1'b0;
         intr  <= 1'b0;
      end
      else if (clr)
      begin
         rhRdy <= 1'b1;
         ieReg <= 1'b0;
         intr  <= 1'b0;
      end
      else
      begin
         // One-cycle pulse after the last word
         intr <= wcWrap && ieReg;

         // IE taken from the same word as GO
         if (cs1LoLoad)
         begin
            ieReg <= devData.cs1.ie;
         end

         // GO and wrap cannot meet, wrap needs busy
         if (goStart)
         begin
            rhRdy <= 1'b0;
         end
         else if (wcWrap)
         begin
            rhRdy <= 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Status word
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      rhCs1                    = '0;
      // GO self-clears, reads back as zero
      rhCs1[Cs1GoBit]          = 1'b0;
      rhCs1[Cs1IeBit]          = ieReg;
      rhCs1[Cs1RdyBit]         = rhRdy;
      // BAE is stored in the address register
      rhCs1[Cs1BaeLsb +: 2]    = baExt;
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   // Idle holds until an accepted GO
   xferRdyHold : assert property (@(posedge clk) disable iff (rst)
      (rhRdy && !goStart) |=> rhRdy)
   else
      $error("rhRdy fell without GO");

   // Interrupt only after the controller went ready
   xferIntrReady : assert property (@(posedge clk) disable iff (rst)
      intr |-> rhRdy)
   else
      $error("intr while busy");

   // BAE written through CS1 shows up in the status word
   xferBaeEcho : assert property (@(posedge clk) disable iff (rst)
      (cs1Write && devHiByte && rhRdy && !clr) |=>
         (rhCs1[Cs1BaeLsb +: 2] == $past(devData.cs1.bae)))
   else
      $error("BAE in rhCs1 does not match the CS1 write");

endmodule

//--- logic/rhWordCount.sv
// RHWC word count register: byte-lane CPU writes, count up per DMA word, flag the wrap to zero
`timescale 1ns/100ps

module rhWordCount
(
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         clr,
   input  logic                         devLoByte,
   input  logic                         devHiByte,
   input  rh11Pkg::devWord_t            devData,
   input  logic                         wcWrite,
   input  logic                         stepXfer,
   output logic [rh11Pkg::WcWidth-1:0]  rhWc,
   output logic                         wcWrap
);

   import rh11Pkg::*;

   //////////////////////////////////////////////////////////////////////
   // Step and wrap
   //////////////////////////////////////////////////////////////////////

   // Count holds minus the words left
   logic wcStepEn;

   // A write on the step cycle cancels the step
   assign wcStepEn = stepXfer && !wcWrite;

   // Last word of the block, count about to reach zero
   assign wcWrap = wcStepEn && (rhWc == '1);

   //////////////////////////////////////////////////////////////////////
   // Count register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rhWc <= '0;
      end
      else if (clr)
      begin
         rhWc <= '0;
      end
      else if (wcWrite)
      begin
         // Lanes land independently
         if (devHiByte)
         begin
            rhWc[15:8] <= devData.bytes.hi;
         end
         if (devLoByte)
         begin
            rhWc[7:0] <= devData.bytes.lo;
         end
      end
      else if (wcStepEn)
      begin
         rhWc <= rhWc + 1'b1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   // Unwritten step counts one word
   wcStepCount : assert property (@(posedge clk) disable iff (rst)
      (wcStepEn && !clr) |=> (rhWc == WcWidth'($past(rhWc) + 1'b1)))
   else
      $error("rhWc did not count one word on a step");

   // Wrap leaves an empty count behind
   wcWrapToZero : assert property (@(posedge clk) disable iff (rst)
      wcWrap |=> (rhWc == '0))
   else
      $error("rhWc not zero after wrap");

endmodule

//--- logic/rhBusAddr.sv
// RHBA bus address register: byte-lane CPU writes, BAE load from CS1, advance on each DMA word
`timescale 1ns/100ps

module rhBusAddr
(
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         clr,
   input  logic                         devLoByte,
   input  logic                         devHiByte,
   input  rh11Pkg::devWord_t            devData,
   input  logic                         baWrite,
   input  logic                         cs1Write,
   input  logic                         rhRdy,
   input  logic                         stepXfer,
   output logic [rh11Pkg::BaWidth-1:0]  rhBa
);

   import rh11Pkg::*;

   //////////////////////////////////////////////////////////////////////
   // Write decode
   //////////////////////////////////////////////////////////////////////

   // Extension bits only move while the controller is idle
   logic baeLoad;

   // Either lane written blocks the step this cycle
   logic baStepEn;

   assign baeLoad  = cs1Write && devHiByte && rhRdy;
   assign baStepEn = stepXfer && !baWrite;

   //////////////////////////////////////////////////////////////////////
   // Address register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rhBa <= '0;
      end
      else if (clr)
      begin
         rhBa <= '0;
      end
      else
      begin
         // BAE from the CS1 high byte
         if (baeLoad)
         begin
            rhBa[17:16] <= devData.cs1.bae;
         end

         // CPU write wins over the step
         if (baWrite)
         begin
            if (devHiByte)
            begin
               rhBa[15:8] <= devData.bytes.hi;
            end
            if (devLoByte)
            begin
               rhBa[7:0] <= devData.bytes.lo;
            end
         end
         else if (baStepEn)
         begin
            // Wraps across all 18 bits, carry reaches BAE
            rhBa <= rhBa + BaStep;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   // Unwritten step advances one word, modulo 2^18
   baStepAdvance : assert property (@(posedge clk) disable iff (rst)
      (baStepEn && !clr) |=> (rhBa == BaWidth'($past(rhBa) + BaStep)))
   else
      $error("rhBa did not advance by one word on a step");

endmodule

//--- logic/rh11Pkg.sv
// Shared RH11 DMA register widths, CS1 bit positions and device word views; import in every RTL block
package rh11Pkg;

   //////////////////////////////////////////////////////////////////////
   // Register widths
   //////////////////////////////////////////////////////////////////////

   // Device data bus, PDP-10 word
   localparam int DevWidth = 36;

   // Unibus address held in RHBA
   localparam int BaWidth = 18;

   // Word count held in RHWC
   localparam int WcWidth = 16;

   //////////////////////////////////////////////////////////////////////
   // RHCS1 bit positions, low 16 bits of the word
   //////////////////////////////////////////////////////////////////////

   // Go, starts the transfer
   localparam int Cs1GoBit = 0;

   // Interrupt enable
   localparam int Cs1IeBit = 6;

   // Controller ready
   localparam int Cs1RdyBit = 7;

   // Low bit of the two-bit bus address extension
   localparam int Cs1BaeLsb = 8;

   // Address advance per word moved, bytes
   localparam logic [BaWidth-1:0] BaStep = BaWidth'(2);

   //////////////////////////////////////////////////////////////////////
   // Device word, two decodings of the same 36 bits
   //////////////////////////////////////////////////////////////////////

   // CS1 field layout
   typedef struct packed
   {
      logic [19:0] unused;
      logic [5:0]  rsvd;
      logic [1:0]  bae;
      logic        rdy;
      logic        ie;
      logic [4:0]  fnc;
      logic        go;
   } cs1View_t;

   // Byte lanes of a 16-bit register write
   typedef struct packed
   {
      logic [19:0] unused;
      logic [7:0]  hi;
      logic [7:0]  lo;
   } byteView_t;

   // Counters read the byte view, the controller reads the CS1 view
   typedef union packed
   {
      cs1View_t  cs1;
      byteView_t bytes;
   } devWord_t;

endpackage
